// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cache_tb
FILELIST  = files.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: files.f
hw/cache_pkg.sv
hw/cache_sram.sv
hw/cache_tag_check.sv
hw/cache_line_data.sv
hw/cache_fsm.sv
hw/cache_top.sv
sim/cache_checker.sv
sim/cache_tb.sv

// File: hw/cache_fsm.sv
`timescale 1ns/100ps

module cache_fsm
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cpu_read,
    input  logic     cpu_write,
    input  logic     hit,
    input  logic     clean_miss,
    input  logic     dirty_miss,
    input  logic     mem_resp,
    output sram_op_t sram_op,
    output logic     ufp_resp,
    output logic     dfp_read,
    output logic     dfp_write
);

    typedef enum logic [1:0] {
        idle,
        compare_tag,
        write_back,
        allocate
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // next state.
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (cpu_read || cpu_write) begin
                    next_state = compare_tag;
                end
            end
            compare_tag: begin
                if (dirty_miss) begin
                    next_state = write_back;   // victim goes out first.
                end else if (clean_miss) begin
                    next_state = allocate;
                end else if (hit) begin
                    next_state = idle;
                end
            end
            write_back: begin
                if (mem_resp) begin
                    next_state = allocate;
                end
            end
            allocate: begin
                if (mem_resp) begin
                    next_state = idle;  // the held request hits on the next pass.
                end
            end
            default: next_state = idle;
        endcase
    end

    // outputs follow the state and this cycle's inputs.
    always_comb begin
        sram_op   = op_none;
        ufp_resp  = 1'b0;
        dfp_read  = 1'b0;
        dfp_write = 1'b0;
        case (state)
            compare_tag: begin
                if (hit) begin
                    ufp_resp = 1'b1;
                    if (cpu_read) begin
                        sram_op = hit_read_clean;
                    end else if (cpu_write) begin
                        sram_op = hit_write_dirty;
                    end
                end
            end
            write_back: begin
                dfp_write = 1'b1;
            end
            allocate: begin
                dfp_read = 1'b1;
                if (mem_resp) begin
                    sram_op = miss_replace;
                end
            end
            default: ;
        endcase
    end

    a_no_rd_wr: assert property (
        @(posedge clk) disable iff (rst) !(dfp_read && dfp_write)
    ) else $error("cache_fsm: memory read and write together");

    // a hit always passes through idle before the next response.
    a_resp_pulse: assert property (
        @(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp
    ) else $error("cache_fsm: ufp_resp high on two consecutive cycles");

endmodule

// File: hw/cache_line_data.sv
`timescale 1ns/100ps

module cache_line_data
    import cache_pkg::*;
#(
    parameter int SET_BITS   = DEF_SET_BITS,
    parameter int WORD_WIDTH = DEF_WORD_WIDTH,
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [SET_BITS-1:0]              index,
    input  logic [$clog2(LINE_WORDS)-1:0]    word_sel,
    input  logic [WORD_WIDTH-1:0]            wdata,
    input  logic [LINE_WORDS*WORD_WIDTH-1:0] fill_line,
    input  sram_op_t                         sram_op,
    output logic [WORD_WIDTH-1:0]            rdata,
    output logic [LINE_WORDS*WORD_WIDTH-1:0] line
);

    typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t;

    line_t stored;
    line_t merged;
    line_t new_line;
    logic  line_we;

    cache_sram #(
        .SET_BITS (SET_BITS),
        .entry_t  (line_t)
    ) i_line_sram (
        .clk   (clk),
        .rst   (rst),
        .index (index),
        .we    (line_we),
        .wdata (new_line),
        .rdata (stored)
    );

    assign rdata = stored[word_sel];
    assign line  = stored;  // also the write-back data.

    // hit write replaces one word and keeps the rest of the line.
    always_comb begin
        merged           = stored;
        merged[word_sel] = wdata;
    end

    always_comb begin
        new_line = merged;
        line_we  = 1'b0;
        case (sram_op)
            hit_write_dirty: begin
                line_we = 1'b1;
            end
            miss_replace: begin
                new_line = fill_line;  // whole line from memory.
                line_we  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/cache_pkg.sv
package cache_pkg;

    // default geometry, byte addressed.
    localparam int DEF_ADDR_WIDTH = 16;
    localparam int DEF_SET_BITS   = 4;   // 16 sets.
    localparam int DEF_WORD_WIDTH = 32;
    localparam int DEF_LINE_WORDS = 4;

    localparam int DEF_BYTE_BITS = $clog2(DEF_WORD_WIDTH / 8);
    localparam int DEF_WORD_BITS = $clog2(DEF_LINE_WORDS);
    localparam int DEF_TAG_WIDTH = DEF_ADDR_WIDTH - DEF_SET_BITS
                                 - DEF_WORD_BITS - DEF_BYTE_BITS;

    // storage operation issued by the controller to both arrays.
    typedef enum logic [1:0] {
        op_none,           // no change.
        hit_read_clean,    // read hit, storage untouched.
        hit_write_dirty,   // merge one word, mark dirty.
        miss_replace       // line fill, new tag, valid and clean.
    } sram_op_t;

    // one tag entry per set.
    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [DEF_TAG_WIDTH-1:0] tag;
    } tag_entry_t;

endpackage

// File: hw/cache_sram.sv
`timescale 1ns/100ps

module cache_sram #(
    parameter int  SET_BITS = 4,
    parameter type entry_t  = logic
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [SET_BITS-1:0] index,
    input  logic                we,
    input  entry_t              wdata,
    output entry_t              rdata
);

    localparam int DEPTH = 2 ** SET_BITS;

    entry_t mem [DEPTH];

    // write on the edge, cleared on reset so tags start invalid.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];  // combinational lookup.

    // an unknown write enable would corrupt an arbitrary set.
    a_we_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(we)
    ) else $error("cache_sram: write enable unknown");

endmodule

// File: hw/cache_tag_check.sv
`timescale 1ns/100ps

module cache_tag_check
    import cache_pkg::*;
#(
    parameter int SET_BITS  = DEF_SET_BITS,
    parameter int TAG_WIDTH = DEF_TAG_WIDTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [SET_BITS-1:0]  index,
    input  logic [TAG_WIDTH-1:0] req_tag,
    input  sram_op_t             sram_op,
    output logic                 hit,
    output logic                 clean_miss,
    output logic                 dirty_miss,
    output logic [TAG_WIDTH-1:0] victim_tag
);

    tag_entry_t entry;
    tag_entry_t new_entry;
    logic       tag_eq;
    logic       tag_we;

    // the entry type is fixed by the package, so the tag widths have to agree.
    if (TAG_WIDTH != $bits(tag_entry_t) - 2) begin : g_width_check
        $error("cache_tag_check: TAG_WIDTH does not match tag_entry_t");
    end

    cache_sram #(
        .SET_BITS (SET_BITS),
        .entry_t  (tag_entry_t)
    ) i_tag_sram (
        .clk   (clk),
        .rst   (rst),
        .index (index),
        .we    (tag_we),
        .wdata (new_entry),
        .rdata (entry)
    );

    assign tag_eq = (entry.tag == req_tag);

    // exactly one of the three.
    assign hit        = entry.valid && tag_eq;
    assign dirty_miss = entry.valid && entry.dirty && !tag_eq;
    assign clean_miss = !entry.valid || (!entry.dirty && !tag_eq);

    assign victim_tag = entry.tag;  // address of the line being written back.

    always_comb begin
        new_entry = entry;
        tag_we    = 1'b0;
        case (sram_op)
            hit_write_dirty: begin
                new_entry.dirty = 1'b1;
                tag_we          = 1'b1;
            end
            miss_replace: begin
                new_entry.valid = 1'b1;
                new_entry.dirty = 1'b0;
                new_entry.tag   = req_tag;
                tag_we          = 1'b1;
            end
            default: ;
        endcase
    end

    a_class_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot({hit, clean_miss, dirty_miss})
    ) else $error("cache_tag_check: lookup classification not one-hot");

endmodule

// File: hw/cache_top.sv
`timescale 1ns/100ps

module cache_top
    import cache_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int SET_BITS   = DEF_SET_BITS,
    parameter int WORD_WIDTH = DEF_WORD_WIDTH,
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [ADDR_WIDTH-1:0]            ufp_addr,
    input  logic                             ufp_read,
    input  logic                             ufp_write,
    input  logic [WORD_WIDTH-1:0]            ufp_wdata,
    output logic [WORD_WIDTH-1:0]            ufp_rdata,
    output logic                             ufp_resp,
    output logic [ADDR_WIDTH-1:0]            dfp_addr,
    output logic                             dfp_read,
    output logic                             dfp_write,
    output logic [LINE_WORDS*WORD_WIDTH-1:0] dfp_wdata,
    input  logic [LINE_WORDS*WORD_WIDTH-1:0] dfp_rdata,
    input  logic                             dfp_resp
);

    localparam int BYTE_BITS = $clog2(WORD_WIDTH / 8);
    localparam int WORD_BITS = $clog2(LINE_WORDS);
    localparam int TAG_WIDTH = ADDR_WIDTH - SET_BITS - WORD_BITS - BYTE_BITS;

    logic [TAG_WIDTH-1:0] req_tag;
    logic [TAG_WIDTH-1:0] victim_tag;
    logic [SET_BITS-1:0]  set_index;
    logic [WORD_BITS-1:0] word_sel;
    logic                 hit;
    logic                 clean_miss;
    logic                 dirty_miss;
    sram_op_t             sram_op;

    // tag | set | word | byte.
    assign req_tag   = ufp_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign set_index = ufp_addr[BYTE_BITS+WORD_BITS +: SET_BITS];
    assign word_sel  = ufp_addr[BYTE_BITS +: WORD_BITS];

    // victim line on write back, requested line otherwise.
    assign dfp_addr = {(dfp_write ? victim_tag : req_tag), set_index,
                       {(WORD_BITS + BYTE_BITS){1'b0}}};

    cache_tag_check #(
        .SET_BITS  (SET_BITS),
        .TAG_WIDTH (TAG_WIDTH)
    ) i_tag_check (
        .clk        (clk),
        .rst        (rst),
        .index      (set_index),
        .req_tag    (req_tag),
        .sram_op    (sram_op),
        .hit        (hit),
        .clean_miss (clean_miss),
        .dirty_miss (dirty_miss),
        .victim_tag (victim_tag)
    );

    cache_line_data #(
        .SET_BITS   (SET_BITS),
        .WORD_WIDTH (WORD_WIDTH),
        .LINE_WORDS (LINE_WORDS)
    ) i_line_data (
        .clk       (clk),
        .rst       (rst),
        .index     (set_index),
        .word_sel  (word_sel),
        .wdata     (ufp_wdata),
        .fill_line (dfp_rdata),
        .sram_op   (sram_op),
        .rdata     (ufp_rdata),
        .line      (dfp_wdata)
    );

    cache_fsm i_fsm (
        .clk        (clk),
        .rst        (rst),
        .cpu_read   (ufp_read),
        .cpu_write  (ufp_write),
        .hit        (hit),
        .clean_miss (clean_miss),
        .dirty_miss (dirty_miss),
        .mem_resp   (dfp_resp),
        .sram_op    (sram_op),
        .ufp_resp   (ufp_resp),
        .dfp_read   (dfp_read),
        .dfp_write  (dfp_write)
    );

endmodule

// File: sim/cache_checker.sv
`timescale 1ns/100ps

module cache_checker #(
    parameter int WORD_WIDTH = 32,
    parameter int MAX_VECS   = 128
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ufp_read,
    input  logic                  ufp_write,
    input  logic [WORD_WIDTH-1:0] ufp_rdata,
    input  logic                  ufp_resp,
    input  logic                  dfp_read,
    input  logic                  dfp_write,
    input  logic                  dfp_resp,
    output int                    error_count,
    output logic                  done
);

    logic [87:0] vec [MAX_VECS];  // op | addr | wdata | expected rdata | kind.
    int n_vec;
    int idx;
    int cyc;     // cycles the current request has been presented.
    int rd_cnt;
    int wr_cnt;
    int pass_cnt;
    int fail_cnt;

    initial begin
        for (int i = 0; i < MAX_VECS; i++) begin
            vec[i] = '0;
        end
        $readmemh("sim/cache_vectors.txt", vec);
        n_vec = 0;
        while (n_vec < MAX_VECS && vec[n_vec][87:84] != 4'h0) begin
            n_vec++;
        end
    end

    task automatic check_access();
        logic [3:0]  op;
        logic [15:0] addr;
        logic [31:0] exp_data;
        logic [3:0]  kind;
        int          errs;
        int          exp_rd;
        int          exp_wr;
        op       = vec[idx][87:84];
        addr     = vec[idx][83:68];
        exp_data = vec[idx][35:4];
        kind     = vec[idx][3:0];
        errs     = 0;
        exp_rd   = (kind == 4'h1) ? 0 : 1;  // every miss fetches one line.
        exp_wr   = (kind == 4'h2) ? 1 : 0;
        if (!ufp_read && !ufp_write) begin
            $display("error at %0t: ufp_resp with no request presented", $time);
            errs++;
        end
        if (op == 4'h1 && ufp_rdata !== exp_data) begin
            $display("mismatch at %0t: ufp_rdata expected %h actual %h",
                     $time, exp_data, ufp_rdata);
            errs++;
        end
        if (rd_cnt != exp_rd) begin
            $display("mismatch at %0t: dfp_read count expected %0d actual %0d",
                     $time, exp_rd, rd_cnt);
            errs++;
        end
        if (wr_cnt != exp_wr) begin
            $display("mismatch at %0t: dfp_write count expected %0d actual %0d",
                     $time, exp_wr, wr_cnt);
            errs++;
        end
        if (kind == 4'h1 && cyc != 2) begin
            $display("mismatch at %0t: ufp_resp latency expected 2 actual %0d", $time, cyc);
            errs++;
        end
        $display("test %0d %s %h: %s", idx, (op == 4'h1) ? "read " : "write", addr,
                 (errs == 0) ? "ok" : "FAILED");
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        error_count += errs;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            idx      = 0;
            cyc      = 0;
            rd_cnt   = 0;
            wr_cnt   = 0;
            pass_cnt = 0;
            fail_cnt = 0;
            done     = 1'b0;
            error_count = 0;
        end else begin
            if (idx == 0 && !ufp_read && !ufp_write && (ufp_resp || dfp_read || dfp_write)) begin
                $display("error at %0t: DUT is active before the first request", $time);
                error_count++;
            end
            if (ufp_read || ufp_write) cyc++;
            if (dfp_resp && dfp_read) rd_cnt++;
            if (dfp_resp && dfp_write) wr_cnt++;
            if (ufp_resp) begin
                if (idx >= n_vec) begin
                    $display("error at %0t: ufp_resp with no access outstanding", $time);
                    error_count++;
                end else begin
                    check_access();
                    idx++;
                    cyc    = 0;
                    rd_cnt = 0;
                    wr_cnt = 0;
                    if (idx == n_vec) begin
                        $display("accesses %0d, passed %0d, failed %0d, errors %0d",
                                 n_vec, pass_cnt, fail_cnt, error_count);
                        done = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: sim/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    localparam int ADDR_WIDTH = 16;
    localparam int WORD_WIDTH = 32;
    localparam int LINE_BITS  = 128;
    localparam int N_LINES    = 4096;  // 64 KB of 16-byte lines.

    logic                  clk = 1'b0;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] ufp_addr;
    logic                  ufp_read;
    logic                  ufp_write;
    logic [WORD_WIDTH-1:0] ufp_wdata;
    logic [WORD_WIDTH-1:0] ufp_rdata;
    logic                  ufp_resp;
    logic [ADDR_WIDTH-1:0] dfp_addr;
    logic                  dfp_read;
    logic                  dfp_write;
    logic [LINE_BITS-1:0]  dfp_wdata;
    logic [LINE_BITS-1:0]  dfp_rdata;
    logic                  dfp_resp;

    logic [87:0]          vec [128];
    int                   n_vec = 0;
    logic [LINE_BITS-1:0] mem_line [N_LINES];
    int                   error_count;
    logic                 done;

    always #50 clk = ~clk;

    cache_top i_cache_top (.*);

    cache_checker #(.WORD_WIDTH(WORD_WIDTH)) i_checker (
        .clk(clk), .rst(rst), .ufp_read(ufp_read),
        .ufp_write(ufp_write), .ufp_rdata(ufp_rdata), .ufp_resp(ufp_resp),
        .dfp_read(dfp_read), .dfp_write(dfp_write), .dfp_resp(dfp_resp),
        .error_count(error_count), .done(done)
    );

    // cpu side, one access at a time.
    initial begin
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_read  = 1'b0;
        ufp_write = 1'b0;
        ufp_wdata = '0;
        for (int i = 0; i < 128; i++) begin
            vec[i] = '0;
        end
        $readmemh("sim/cache_vectors.txt", vec);
        while (n_vec < 128 && vec[n_vec][87:84] != 4'h0) n_vec++;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < n_vec; i++) begin
            ufp_read  <= (vec[i][87:84] == 4'h1);
            ufp_write <= (vec[i][87:84] == 4'h2);
            ufp_addr  <= vec[i][83:68];
            ufp_wdata <= vec[i][67:36];
            do @(posedge clk); while (!ufp_resp);  // next access goes out on this edge.
        end
        ufp_read  <= 1'b0;
        ufp_write <= 1'b0;
        repeat (4) @(posedge clk);
        if (n_vec == 0) $display("error: the vector file holds no accesses");
        if (!done) $display("error: the checker did not see every access complete");
        if (n_vec > 0 && done && error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // main memory with a random response delay of 1 to 8 cycles.
    initial begin
        int          wait_cnt;
        logic        busy;
        logic [15:0] a;
        void'($urandom(32'heee8e388));
        busy      = 1'b0;
        wait_cnt  = 0;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        for (int l = 0; l < N_LINES; l++) begin
            for (int w = 0; w < 4; w++) begin
                a = 16'(l * 16 + w * 4);
                mem_line[l][w*32 +: 32] = {a, a};  // word holds its own byte address twice.
            end
        end
        forever begin
            @(posedge clk);
            dfp_resp <= 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_cnt > 1) begin
                    wait_cnt--;
                end else begin
                    busy = 1'b0;
                    dfp_resp <= 1'b1;
                    if (dfp_write) begin
                        mem_line[dfp_addr[15:4]] = dfp_wdata;
                    end else begin
                        dfp_rdata <= mem_line[dfp_addr[15:4]];
                    end
                end
            end else if (!dfp_resp && (dfp_read || dfp_write)) begin
                busy     = 1'b1;
                wait_cnt = int'($urandom_range(8, 1));
            end
        end
    end

    // watchdog.
    initial begin
        #1;
        repeat (16 + n_vec * 40) @(posedge clk);
        $display("timeout: the accesses did not complete within %0d cycles", 16 + n_vec * 40);
        $display("Errors found");
        $finish;
    end

endmodule

// File: sim/cache_vectors.txt
// op(1 read, 2 write) _ addr _ wdata _ expected rdata _ kind
// kind: 0 clean miss, 1 hit, 2 dirty miss
1_0010_00000000_00100010_0
1_0014_00000000_00140014_1
2_0018_a5a50001_00000000_1
1_0018_00000000_a5a50001_1
1_001c_00000000_001c001c_1
// dirty eviction of line 0010
1_0110_00000000_01100110_2
1_0018_00000000_a5a50001_0
1_0014_00000000_00140014_1
// clean eviction
1_0210_00000000_02100210_0
2_0224_12345678_00000000_0
1_0224_00000000_12345678_1
2_0228_deadbeef_00000000_1
2_0324_cafef00d_00000000_2
1_0324_00000000_cafef00d_1
1_0228_00000000_deadbeef_2
1_0224_00000000_12345678_1
1_0320_00000000_03200320_0
1_0324_00000000_cafef00d_1
// set 3 ping-pong
2_0430_11110000_00000000_0
2_0534_22220000_00000000_2
2_0638_33330000_00000000_2
1_0430_00000000_11110000_2
1_0534_00000000_22220000_0
1_0638_00000000_33330000_0
// set f
1_fff0_00000000_fff0fff0_0
1_fffc_00000000_fffcfffc_1
2_00f0_0badc0de_00000000_0
1_fff4_00000000_fff4fff4_2
1_00f0_00000000_0badc0de_0
// set 4
1_0040_00000000_00400040_0
1_0044_00000000_00440044_1
2_0048_aaaa5555_00000000_1
1_0048_00000000_aaaa5555_1
1_1040_00000000_10401040_2
1_0048_00000000_aaaa5555_0
